/* rtl/gfx_pkg.sv */
// ====================
// shared types and constants for the line drawing display:
// raster timing, framebuffer geometry, letterbox and palette
// ====================
`default_nettype none

package gfx_pkg;

    localparam int cordw = 16;                      // signed coordinate width
    typedef logic signed [cordw-1:0] coord_t;

    // 640x480 horizontal timing in pixels
    localparam int h_active = 640;
    localparam int h_fp     = 16;
    localparam int h_sync   = 96;
    localparam int h_bp     = 48;
    localparam int h_total  = h_active + h_fp + h_sync + h_bp;  // 800
    localparam int hs_start = h_active + h_fp;                 // first hsync pixel
    localparam int hs_end   = hs_start + h_sync;               // first pixel after hsync

    // vertical timing in lines
    localparam int v_active = 480;
    localparam int v_fp     = 10;
    localparam int v_sync   = 2;
    localparam int v_bp     = 33;
    localparam int v_total  = v_active + v_fp + v_sync + v_bp;  // 525
    localparam int vs_start = v_active + v_fp;
    localparam int vs_end   = vs_start + v_sync;

    // framebuffer geometry
    localparam int fb_width  = 160;
    localparam int fb_height = 90;
    localparam int fb_scale  = 4;                   // screen pixels per fb pixel
    localparam int fb_shift  = $clog2(fb_scale);
    localparam int fb_depth  = fb_width * fb_height;
    localparam int fb_addrw  = $clog2(fb_depth);

    // 16:9 letterbox inside the 4:3 raster
    localparam int lb_top    = 60;
    localparam int lb_bottom = lb_top + fb_height * fb_scale;  // 420

    // colour
    localparam int cidxw = 2;
    typedef logic [cidxw-1:0] cidx_t;
    localparam int chanw = 4;

    // 12-bit RGB entries, red in the top nibble
    localparam logic [3*chanw-1:0] palette [2**cidxw] = '{
        12'h000,  // black
        12'hF00,  // red
        12'h0F0,  // green
        12'hFFF   // white
    };

endpackage

`default_nettype wire

/* rtl/fb_write_if.sv */
// ====================
// pixel write path from the line drawer into the framebuffer
// ====================
`default_nettype none
`timescale 1ns/10ps

interface fb_write_if;

    logic            we;    // pixel valid
    gfx_pkg::coord_t x;
    gfx_pkg::coord_t y;
    gfx_pkg::cidx_t  cidx;  // colour index to store
    logic            busy;  // framebuffer refuses writes

    modport drawer (
        output we,
        output x,
        output y,
        output cidx,
        input  busy
    );

    modport fb (
        input  we,
        input  x,
        input  y,
        input  cidx,
        output busy
    );

endinterface

`default_nettype wire

/* rtl/display_timings.sv */
// ====================
// 640x480 raster counters with syncs, data enable and
// frame and line pulses, all registered alongside sx and sy
// ====================
`default_nettype none
`timescale 1ns/10ps

module display_timings (
    input  logic            clk_pix,
    input  logic            rst_n,
    output gfx_pkg::coord_t sx,
    output gfx_pkg::coord_t sy,
    output logic            hsync,
    output logic            vsync,
    output logic            de,
    output logic            frame,
    output logic            line
);

    gfx_pkg::coord_t sx_next;
    gfx_pkg::coord_t sy_next;

    // next position, decoded before the register so flags line up
    always_comb begin
        if (sx == gfx_pkg::coord_t'(gfx_pkg::h_total - 1)) begin
            sx_next = '0;
            if (sy == gfx_pkg::coord_t'(gfx_pkg::v_total - 1)) begin
                sy_next = '0;
            end else begin
                sy_next = sy + 1'b1;
            end
        end else begin
            sx_next = sx + 1'b1;
            sy_next = sy;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx    <= gfx_pkg::coord_t'(gfx_pkg::h_active);      // start in blanking
            sy    <= gfx_pkg::coord_t'(gfx_pkg::v_total - 1);   // last line of frame
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
            frame <= 1'b0;
            line  <= 1'b0;
        end else begin
            sx    <= sx_next;
            sy    <= sy_next;
            // both syncs active low
            hsync <= !(sx_next >= gfx_pkg::hs_start && sx_next < gfx_pkg::hs_end);
            vsync <= !(sy_next >= gfx_pkg::vs_start && sy_next < gfx_pkg::vs_end);
            de    <= sx_next < gfx_pkg::h_active && sy_next < gfx_pkg::v_active;
            frame <= sx_next == 0 && sy_next == 0;
            line  <= sx_next == 0;
        end
    end

endmodule

`default_nettype wire

/* rtl/line_drawer.sv */
// ====================
// Bresenham line rasteriser for all octants
// one pixel per cycle into the framebuffer, stalled by busy
// ====================
`default_nettype none
`timescale 1ns/10ps

module line_drawer (
    input  logic            clk_pix,
    input  logic            rst_n,
    input  logic            start,
    input  gfx_pkg::coord_t x0,
    input  gfx_pkg::coord_t y0,
    input  gfx_pkg::coord_t x1,
    input  gfx_pkg::coord_t y1,
    input  gfx_pkg::cidx_t  cidx,
    output logic            drawing,
    output logic            done,
    fb_write_if.drawer      wr
);

    typedef enum logic [1:0] {IDLE, INIT, DRAW} state_t;
    typedef logic signed [gfx_pkg::cordw:0] delta_t;  // one bit wider than a coordinate

    state_t                state;
    gfx_pkg::coord_t       xc;        // current pixel
    gfx_pkg::coord_t       yc;
    gfx_pkg::coord_t       xe;        // end point
    gfx_pkg::coord_t       ye;
    gfx_pkg::cidx_t        colour;
    logic                  right;     // x steps up
    logic                  down;      // y steps up
    delta_t                dx;        // |x1-x0|
    delta_t                dy;        // -|y1-y0|
    delta_t                err;
    delta_t                abs_dx;
    delta_t                neg_dy;
    logic signed [gfx_pkg::cordw+1:0] e2;
    logic                  step_x;
    logic                  step_y;
    logic                  last;
    logic                  emit;

    always_comb begin
        // deltas from the latched endpoints, used in INIT
        if (xe > xc) begin
            abs_dx = delta_t'(xe) - delta_t'(xc);
        end else begin
            abs_dx = delta_t'(xc) - delta_t'(xe);
        end
        if (ye > yc) begin
            neg_dy = delta_t'(yc) - delta_t'(ye);
        end else begin
            neg_dy = delta_t'(ye) - delta_t'(yc);
        end

        e2     = err <<< 1;
        step_x = e2 >= dy;
        step_y = e2 <= dx;
        last   = xc == xe && yc == ye;
        emit   = state == DRAW && !wr.busy;  // never write into a busy fb
    end

    assign drawing = state != IDLE;
    assign wr.we   = emit;
    assign wr.x    = xc;
    assign wr.y    = yc;
    assign wr.cidx = colour;

    // control
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE:    if (start) state <= INIT;
                INIT:    state <= DRAW;
                DRAW: begin
                    if (emit && last) begin
                        state <= IDLE;
                        done  <= 1'b1;  // one cycle after the end pixel
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk_pix) begin
        case (state)
            IDLE: begin
                if (start) begin
                    xc     <= x0;
                    yc     <= y0;
                    xe     <= x1;
                    ye     <= y1;
                    colour <= cidx;
                end
            end
            INIT: begin
                dx    <= abs_dx;
                dy    <= neg_dy;
                err   <= abs_dx + neg_dy;
                right <= xc < xe;
                down  <= yc < ye;
            end
            DRAW: begin
                if (emit && !last) begin
                    if (step_x) xc <= right ? xc + 1'b1 : xc - 1'b1;
                    if (step_y) yc <= down ? yc + 1'b1 : yc - 1'b1;
                    err <= err + (step_x ? dy : delta_t'(0)) + (step_y ? dx : delta_t'(0));
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/framebuffer.sv */
// ====================
// 160x90 colour index store with clear after reset, clipped writes,
// and a 4x scaled letterboxed read with palette lookup
// ====================
`default_nettype none
`timescale 1ns/10ps

module framebuffer (
    input  logic                      clk_pix,
    input  logic                      rst_n,
    fb_write_if.fb                    wr,
    input  gfx_pkg::coord_t           sx,
    input  gfx_pkg::coord_t           sy,
    input  logic                      de,
    output logic [gfx_pkg::chanw-1:0] red,
    output logic [gfx_pkg::chanw-1:0] green,
    output logic [gfx_pkg::chanw-1:0] blue
);

    typedef logic [gfx_pkg::fb_addrw-1:0] addr_t;

    gfx_pkg::cidx_t mem [gfx_pkg::fb_depth];

    logic                        clearing;
    addr_t                       clr_addr;
    logic                        in_lb;     // sy inside the letterbox
    logic                        busy;
    logic                        in_range;  // write lands inside the fb
    logic                        wr_ok;
    logic                        show;
    gfx_pkg::coord_t             rd_x;
    gfx_pkg::coord_t             rd_y;
    addr_t                       rd_addr;
    addr_t                       wr_addr;
    addr_t                       addr;
    logic                        mem_we;
    gfx_pkg::cidx_t              mem_din;
    gfx_pkg::cidx_t              mem_dout;
    logic [3*gfx_pkg::chanw-1:0] rgb;

    // wipe every entry to index 0, one per cycle
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            clearing <= 1'b1;
            clr_addr <= '0;
        end else if (clearing) begin
            if (clr_addr == addr_t'(gfx_pkg::fb_depth - 1)) clearing <= 1'b0;
            clr_addr <= clr_addr + 1'b1;
        end
    end

    always_comb begin
        in_lb = sy >= gfx_pkg::lb_top && sy < gfx_pkg::lb_bottom;
        busy  = clearing || (in_lb && sx < gfx_pkg::h_active);  // scanout owns the port

        in_range = wr.x >= 0 && wr.x < gfx_pkg::fb_width &&
                   wr.y >= 0 && wr.y < gfx_pkg::fb_height;
        wr_ok    = wr.we && !busy && in_range;                  // out of range is clipped
        wr_addr  = addr_t'(wr.y * gfx_pkg::fb_width + wr.x);

        // scale down and shift up by the letterbox
        rd_x    = sx >>> gfx_pkg::fb_shift;
        rd_y    = (sy - gfx_pkg::coord_t'(gfx_pkg::lb_top)) >>> gfx_pkg::fb_shift;
        rd_addr = addr_t'(rd_y * gfx_pkg::fb_width + rd_x);

        show = de && in_lb && !clearing;
    end

    assign wr.busy = busy;

    // one port shared by clear, draw and scanout
    always_comb begin
        if (clearing) begin
            addr    = clr_addr;
            mem_din = '0;
        end else if (wr_ok) begin
            addr    = wr_addr;
            mem_din = wr.cidx;
        end else begin
            addr    = rd_addr;
            mem_din = wr.cidx;
        end
        mem_we = clearing || wr_ok;
    end

    always_ff @(posedge clk_pix) begin
        if (mem_we) mem[addr] <= mem_din;
    end

    assign mem_dout = mem[addr];
    assign rgb      = gfx_pkg::palette[mem_dout];

    // colour is ready one cycle after sx, sy
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (show) begin
            red   <= rgb[3*gfx_pkg::chanw-1:2*gfx_pkg::chanw];
            green <= rgb[2*gfx_pkg::chanw-1:gfx_pkg::chanw];
            blue  <= rgb[gfx_pkg::chanw-1:0];
        end else begin
            red   <= '0;  // black border and blanking
            green <= '0;
            blue  <= '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/line_display_top.sv */
// ====================
// line drawing display top level
// takes line requests and scans the framebuffer out as 640x480 video
// ====================
`default_nettype none
`timescale 1ns/10ps

module line_display_top (
    input  logic                      clk_pix,
    input  logic                      rst_n,
    input  logic                      draw_start,
    input  gfx_pkg::coord_t           draw_x0,
    input  gfx_pkg::coord_t           draw_y0,
    input  gfx_pkg::coord_t           draw_x1,
    input  gfx_pkg::coord_t           draw_y1,
    input  gfx_pkg::cidx_t            draw_cidx,
    output logic                      drawing,
    output logic                      draw_done,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      de,
    output logic [gfx_pkg::chanw-1:0] red,
    output logic [gfx_pkg::chanw-1:0] green,
    output logic [gfx_pkg::chanw-1:0] blue
);

    gfx_pkg::coord_t sx;
    gfx_pkg::coord_t sy;
    logic            tim_hsync;
    logic            tim_vsync;
    logic            tim_de;

    fb_write_if fb_wr ();

    display_timings display_timings_i (
        .clk_pix,
        .rst_n,
        .sx,
        .sy,
        .hsync (tim_hsync),
        .vsync (tim_vsync),
        .de    (tim_de),
        .frame (),        // raster markers not needed at this level
        .line  ()
    );

    line_drawer line_drawer_i (
        .clk_pix,
        .rst_n,
        .start   (draw_start),
        .x0      (draw_x0),
        .y0      (draw_y0),
        .x1      (draw_x1),
        .y1      (draw_y1),
        .cidx    (draw_cidx),
        .drawing,
        .done    (draw_done),
        .wr      (fb_wr.drawer)
    );

    framebuffer framebuffer_i (
        .clk_pix,
        .rst_n,
        .wr    (fb_wr.fb),
        .sx,
        .sy,
        .de    (tim_de),
        .red,
        .green,
        .blue
    );

    // match the one cycle framebuffer read
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            hsync <= 1'b1;  // inactive high
            vsync <= 1'b1;
            de    <= 1'b0;
        end else begin
            hsync <= tim_hsync;
            vsync <= tim_vsync;
            de    <= tim_de;
        end
    end

endmodule

`default_nettype wire

/* bench/line_display_properties.sv */
// ====================
// concurrent checks on the draw handshake and the framebuffer
// write gating, bound into the line display top level
// ====================
`default_nettype none
`timescale 1ns/10ps

module line_display_properties (
    input logic            clk_pix,
    input logic            rst_n,
    input logic            drawing,
    input logic            draw_done,
    input logic            we,
    input logic            busy,
    input gfx_pkg::coord_t x,
    input gfx_pkg::coord_t y
);

    int unsigned fail_count = 0;  // summed into the testbench result

    done_single: assert property (@(posedge clk_pix) disable iff (!rst_n)
        draw_done |=> !draw_done)
        else begin
            fail_count++;
            $error("draw_done stayed high for two cycles");
        end

    done_after_drawing: assert property (@(posedge clk_pix) disable iff (!rst_n)
        draw_done |-> $past(drawing))
        else begin
            fail_count++;
            $error("draw_done without drawing in the previous cycle");
        end

    // a stalled drawer neither writes nor moves on
    stall_holds_pixel: assert property (@(posedge clk_pix) disable iff (!rst_n)
        drawing && busy |-> !we ##1 ($stable(x) && $stable(y)))
        else begin
            fail_count++;
            $error("drawer wrote or stepped while the framebuffer was busy");
        end

endmodule

bind line_display_top line_display_properties props_i (
    .clk_pix,
    .rst_n,
    .drawing,
    .draw_done,
    .we      (fb_wr.we),
    .busy    (fb_wr.busy),
    .x       (fb_wr.x),
    .y       (fb_wr.y)
);

`default_nettype wire

/* bench/tb_line_display.sv */
// ====================
// testbench for the line display: random lines against a framebuffer
// model, then a scanned frame checked for colour and raster timing
// ====================
`default_nettype none
`timescale 1ns/10ps

module tb_line_display;

    localparam int n_lines    = 24;
    localparam int frame_cyc  = gfx_pkg::h_total * gfx_pkg::v_total;
    localparam int max_cycles = 6 * frame_cyc;  // clear, lines, two scanned frames

    logic                      clk_pix;
    logic                      rst_n;
    logic                      draw_start;
    gfx_pkg::coord_t           draw_x0, draw_y0, draw_x1, draw_y1;
    gfx_pkg::cidx_t            draw_cidx;
    logic                      drawing;
    logic                      draw_done;
    logic                      hsync;
    logic                      vsync;
    logic                      de;
    logic [gfx_pkg::chanw-1:0] red, green, blue;

    gfx_pkg::cidx_t model [gfx_pkg::fb_height][gfx_pkg::fb_width];
    logic [31:0]    rng    = 32'he537_36cf;
    int             errors = 0;
    int             checks = 0;
    int             dones  = 0;
    int             cycles = 0;

    line_display_top dut_i (.*);

    initial begin
        clk_pix = 1'b0;
        forever #4 clk_pix = ~clk_pix;
    end

    always @(posedge clk_pix) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("run stopped at the cycle limit of %0d", max_cycles);
            $display("checks %0d, errors %0d", checks, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    always @(negedge clk_pix) begin
        if (rst_n && draw_done) dones++;
    end

    function automatic int rand_int(input int lo, input int hi);
        rng = rng * 32'd1664525 + 32'd1013904223;  // lcg step
        return lo + int'(rng[31:8] % (hi - lo + 1));
    endfunction

    function automatic logic [11:0] rgb_of(input gfx_pkg::cidx_t c);
        case (c)
            2'd1:    return 12'hF00;
            2'd2:    return 12'h0F0;
            2'd3:    return 12'hFFF;
            default: return 12'h000;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_idle();
        check("drawing", drawing, 0);
        check("draw_done", draw_done, 0);
        check("de", de, 0);
        check("{red,green,blue}", {red, green, blue}, 0);
        check("hsync", hsync, 1);
        check("vsync", vsync, 1);
    endtask

    // reference Bresenham walk, pixels outside the fb are dropped
    task automatic model_line(input int x0, y0, x1, y1, input gfx_pkg::cidx_t c);
        int x;
        int y;
        int dx;
        int dy;
        int err;
        int e2;
        bit fin;
        x   = x0;
        y   = y0;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;  // negative magnitude
        err = dx + dy;
        fin = 0;
        while (!fin) begin
            if (x >= 0 && x < gfx_pkg::fb_width && y >= 0 && y < gfx_pkg::fb_height)
                model[y][x] = c;
            if (x == x1 && y == y1) begin
                fin = 1;
            end else begin
                e2 = 2 * err;
                if (e2 >= dy) begin
                    err += dy;
                    x   += (x0 < x1) ? 1 : -1;
                end
                if (e2 <= dx) begin
                    err += dx;
                    y   += (y0 < y1) ? 1 : -1;
                end
            end
        end
    endtask

    task automatic draw_line(input int x0, y0, x1, y1, input gfx_pkg::cidx_t c, input bit poke);
        int n;
        @(negedge clk_pix);
        while (drawing) @(negedge clk_pix);
        @(posedge clk_pix);
        draw_start <= 1'b1;
        draw_x0    <= gfx_pkg::coord_t'(x0);
        draw_y0    <= gfx_pkg::coord_t'(y0);
        draw_x1    <= gfx_pkg::coord_t'(x1);
        draw_y1    <= gfx_pkg::coord_t'(y1);
        draw_cidx  <= c;
        @(posedge clk_pix);
        draw_start <= 1'b0;
        @(negedge clk_pix);
        check("drawing", drawing, 1);
        if (poke) begin
            @(posedge clk_pix);
            draw_start <= 1'b1;  // arrives mid line, must be ignored
            draw_y0    <= gfx_pkg::coord_t'(y0 + 7);
            draw_cidx  <= ~c;
            @(posedge clk_pix);
            draw_start <= 1'b0;
        end
        n = 0;
        @(negedge clk_pix);
        while (!draw_done && n < frame_cyc) begin
            @(negedge clk_pix);
            n++;
        end
        assert (draw_done) else begin
            errors++;
            $display("draw_done never came for line %0d,%0d to %0d,%0d", x0, y0, x1, y1);
        end
        check("drawing", drawing, 0);
        model_line(x0, y0, x1, y1, c);
    endtask

    // one frame from the end of vsync, with colour and raster timing checks
    task automatic scan_frame();
        int          pix;
        int          row;
        int          de_run;
        int          blank;
        int          hs_low;
        int          vs_low;
        int          rows;
        logic        prev_de;
        logic        prev_hs;
        logic [11:0] exp;
        pix     = 0;
        de_run  = 0;
        blank   = frame_cyc;  // no hsync delay check before the first de
        hs_low  = 0;
        vs_low  = 0;
        rows    = 0;
        prev_de = 1'b0;
        prev_hs = 1'b1;
        @(negedge clk_pix);
        while (vsync) @(negedge clk_pix);
        while (!vsync) @(negedge clk_pix);
        repeat (frame_cyc) begin
            exp = 12'h000;
            if (de) begin
                row = pix / gfx_pkg::h_active;
                if (row >= gfx_pkg::lb_top && row < gfx_pkg::lb_bottom)
                    exp = rgb_of(model[(row - gfx_pkg::lb_top) / gfx_pkg::fb_scale]
                                      [(pix % gfx_pkg::h_active) / gfx_pkg::fb_scale]);
                pix++;
                de_run++;
                blank = 0;
            end else begin
                if (prev_de) begin
                    check("de high cycles", de_run, gfx_pkg::h_active);
                    rows++;
                    de_run = 0;
                end
                if (prev_hs && !hsync && blank < gfx_pkg::h_total)
                    check("hsync delay after de", blank, gfx_pkg::h_fp);
                blank++;
            end
            check("{red,green,blue}", {red, green, blue}, exp);
            if (hsync) begin
                if (!prev_hs) check("hsync low cycles", hs_low, gfx_pkg::h_sync);
                hs_low = 0;
            end else begin
                hs_low++;
            end
            if (!vsync) vs_low++;
            prev_de = de;
            prev_hs = hsync;
            @(negedge clk_pix);
        end
        check("active lines", rows, gfx_pkg::v_active);
        check("vsync low cycles", vs_low, gfx_pkg::v_sync * gfx_pkg::h_total);
    endtask

    initial begin
        int             x0;
        int             y0;
        int             x1;
        int             y1;
        int             d;
        gfx_pkg::cidx_t c;
        rst_n      = 1'b0;
        draw_start = 1'b0;
        draw_x0    = '0;
        draw_y0    = '0;
        draw_x1    = '0;
        draw_y1    = '0;
        draw_cidx  = '0;
        foreach (model[r, k]) model[r][k] = '0;

        @(posedge clk_pix);
        @(negedge clk_pix);
        check_idle();
        @(posedge clk_pix);
        rst_n <= 1'b1;
        repeat (2) begin
            @(negedge clk_pix);
            check_idle();  // last reset cycle, then the first one after
        end

        scan_frame();  // nothing drawn yet, all black
        repeat (gfx_pkg::lb_top + 1) @(posedge de);  // draw while scanout holds busy
        for (int i = 0; i < n_lines; i++) begin
            x0 = rand_int(-8, 167);
            y0 = rand_int(-8, 97);
            x1 = rand_int(-8, 167);
            y1 = rand_int(-8, 97);
            c  = gfx_pkg::cidx_t'(rand_int(1, 3));
            case (i)
                0: y1 = y0;  // horizontal
                1: x1 = x0;  // vertical
                2: begin
                    d  = rand_int(10, 60);
                    x1 = x0 + d;
                    y1 = y0 - d;
                end
                3: begin
                    x0 = rand_int(0, gfx_pkg::fb_width - 1);
                    y0 = rand_int(0, gfx_pkg::fb_height - 1);
                    x1 = x0;
                    y1 = y0;
                end
                default: ;
            endcase
            draw_line(x0, y0, x1, y1, c, i[0]);
        end
        scan_frame();

        check("draw_done pulses", dones, n_lines);
        check("bound property failures", dut_i.props_i.fail_count, 0);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
rtl/gfx_pkg.sv
rtl/fb_write_if.sv
rtl/display_timings.sv
rtl/line_drawer.sv
rtl/framebuffer.sv
rtl/line_display_top.sv
bench/line_display_properties.sv
bench/tb_line_display.sv
